/* rtl/l1_cache_macros.svh */
// L1 cache geometry shared by the package, the cache RTL and the testbench
`ifndef L1_CACHE_MACROS_SVH
`define L1_CACHE_MACROS_SVH

// Four ways of 32 sets with 64-byte lines
`define L1_NUM_WAYS 4
`define L1_NUM_SETS 32

// Address split is tag, then set index, then line offset
`define L1_SET_INDEX_WIDTH 5
`define L1_TAG_WIDTH 21
`define L1_OFFSET_WIDTH 6

// One line is 64 bytes
`define L1_LINE_BITS 512

// Hardware strands sharing each cache
`define L1_NUM_STRANDS 4

`endif

/* rtl/l1_cache_pkg.sv */
// L1 cache package with the address-field, way, strand, unit and line types
`default_nettype none

`include "l1_cache_macros.svh"

package l1_cache_pkg;

	// Fields of a virtual address
	typedef logic [`L1_SET_INDEX_WIDTH-1:0] l1_set_t;
	typedef logic [`L1_TAG_WIDTH-1:0] l1_tag_t;

	typedef logic [$clog2(`L1_NUM_WAYS)-1:0] l1_way_t;

	// Strand numbers and masks with one bit per strand
	typedef logic [$clog2(`L1_NUM_STRANDS)-1:0] strand_t;
	typedef logic [`L1_NUM_STRANDS-1:0] strand_mask_t;

	// Unit number of a requester on the L2 buses
	typedef logic [1:0] unit_t;

	typedef logic [`L1_LINE_BITS-1:0] cache_line_t;

	// Line address sent to the L2, tag in the upper bits
	typedef logic [`L1_TAG_WIDTH+`L1_SET_INDEX_WIDTH-1:0] line_addr_t;

endpackage

`default_nettype wire

/* rtl/l1_cache_tag.sv */
// L1 tag store with four ways, registered parallel lookup and fill update
`default_nettype none

`include "l1_cache_macros.svh"

module l1_cache_tag
	(
	input wire clk,
	input wire rst_n_i,
	input wire l1_cache_pkg::l1_set_t lookup_set_i,
	input wire l1_cache_pkg::l1_tag_t lookup_tag_i,
	input wire access_i,
	output l1_cache_pkg::l1_way_t hit_way_o,
	output logic cache_hit_o,
	input wire update_i,
	input wire l1_cache_pkg::l1_set_t update_set_i,
	input wire l1_cache_pkg::l1_tag_t update_tag_i,
	input wire l1_cache_pkg::l1_way_t update_way_i
	);

	import l1_cache_pkg::*;

	l1_tag_t tag_mem [`L1_NUM_WAYS][`L1_NUM_SETS];
	logic [`L1_NUM_SETS-1:0] valid_bits [`L1_NUM_WAYS];
	logic [`L1_NUM_WAYS-1:0] way_match;
	l1_way_t match_way;

	// All ways are compared in the same cycle
	always_comb
	begin
		match_way = '0;
		for (int w = 0; w < `L1_NUM_WAYS; w++)
		begin
			way_match[w] = valid_bits[w][lookup_set_i]
				&& tag_mem[w][lookup_set_i] == lookup_tag_i;
			if (way_match[w])
				match_way = l1_way_t'(w);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			cache_hit_o <= 1'b0;
			hit_way_o <= '0;
			for (int w = 0; w < `L1_NUM_WAYS; w++)
				valid_bits[w] <= '0;
		end
		else
		begin
			cache_hit_o <= access_i && |way_match;
			hit_way_o <= match_way;
			if (update_i)
				valid_bits[update_way_i][update_set_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (update_i)
			tag_mem[update_way_i][update_set_i] <= update_tag_i;
	end

	// The collision check in the cache keeps a line out of two ways
	assert property (@(posedge clk) disable iff (!rst_n_i)
		access_i |-> $onehot0(way_match))
		else $error("line present in more than one way");

endmodule

`default_nettype wire

/* rtl/l1_cache_lru.sv */
// Tree pseudo-LRU state per set, giving the victim way and recording each use
`default_nettype none

`include "l1_cache_macros.svh"

module l1_cache_lru
	(
	input wire clk,
	input wire rst_n_i,
	input wire l1_cache_pkg::l1_set_t set_i,
	input wire update_i,
	input wire l1_cache_pkg::l1_way_t used_way_i,
	output l1_cache_pkg::l1_way_t lru_way_o
	);

	import l1_cache_pkg::*;

	// Bit 0 picks the pair, bit 1 picks within ways 0 and 1, bit 2 within ways 2 and 3
	logic [2:0] tree_bits [`L1_NUM_SETS];
	l1_set_t set_q;
	logic [2:0] cur_bits;

	assign cur_bits = tree_bits[set_q];
	assign lru_way_o = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			set_q <= '0;
			for (int s = 0; s < `L1_NUM_SETS; s++)
				tree_bits[s] <= 3'b000;
		end
		else
		begin
			set_q <= set_i;
			if (update_i)
			begin
				// Point every bit on the used path at the other half
				tree_bits[set_q][0] <= ~used_way_i[1];
				if (used_way_i[1])
					tree_bits[set_q][2] <= ~used_way_i[0];
				else
					tree_bits[set_q][1] <= ~used_way_i[0];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/l1_miss_queue.sv */
// Per-strand load miss queue with line merging, round-robin issue and fill completion
`default_nettype none

`include "l1_cache_macros.svh"

module l1_miss_queue
	#(parameter l1_cache_pkg::unit_t UNIT_ID = 2'd0)
	(
	input wire clk,
	input wire rst_n_i,
	input wire request_i,
	input wire l1_cache_pkg::l1_tag_t tag_i,
	input wire l1_cache_pkg::l1_set_t set_i,
	input wire l1_cache_pkg::l1_way_t victim_way_i,
	input wire l1_cache_pkg::strand_t strand_i,
	output logic pci_valid_o,
	input wire pci_ack_i,
	output l1_cache_pkg::strand_t pci_strand_o,
	output l1_cache_pkg::line_addr_t pci_address_o,
	input wire cpi_valid_i,
	input wire l1_cache_pkg::unit_t cpi_unit_i,
	input wire l1_cache_pkg::strand_t cpi_strand_i,
	output l1_cache_pkg::strand_mask_t load_complete_strands_o,
	output l1_cache_pkg::l1_set_t load_complete_set_o,
	output l1_cache_pkg::l1_tag_t load_complete_tag_o,
	output l1_cache_pkg::l1_way_t load_complete_way_o
	);

	import l1_cache_pkg::*;

	localparam int NUM_ENTRIES = `L1_NUM_STRANDS;

	logic [NUM_ENTRIES-1:0] entry_valid;
	logic [NUM_ENTRIES-1:0] entry_issued;
	strand_mask_t entry_waiting [NUM_ENTRIES];
	l1_tag_t entry_tag [NUM_ENTRIES];
	l1_set_t entry_set [NUM_ENTRIES];
	l1_way_t entry_way [NUM_ENTRIES];
	logic [NUM_ENTRIES-1:0] merge_hit;
	logic [NUM_ENTRIES-1:0] pending;
	strand_t merge_idx;
	strand_t rr_ptr;
	strand_t rr_pick;
	strand_t issue_idx;
	strand_t held_idx;
	logic held;
	logic response_match;
	strand_mask_t strand_bit;
	strand_mask_t waiting_all;

	assign strand_bit = strand_mask_t'(1) << strand_i;

	always_comb
	begin
		merge_idx = '0;
		waiting_all = '0;
		for (int e = 0; e < NUM_ENTRIES; e++)
		begin
			merge_hit[e] = entry_valid[e] && entry_tag[e] == tag_i && entry_set[e] == set_i;
			pending[e] = entry_valid[e] && !entry_issued[e];
			waiting_all = waiting_all | entry_waiting[e];
			if (merge_hit[e])
				merge_idx = strand_t'(e);
		end
	end

	// First pending entry at or after the pointer, searched backwards so it wins
	always_comb
	begin
		rr_pick = rr_ptr;
		for (int k = NUM_ENTRIES - 1; k >= 0; k--)
		begin
			if (pending[strand_t'(rr_ptr + k)])
				rr_pick = strand_t'(rr_ptr + k);
		end
	end

	// Once presented, a request keeps its entry until ack
	assign issue_idx = held ? held_idx : rr_pick;
	assign pci_valid_o = |pending;
	assign pci_strand_o = issue_idx;
	assign pci_address_o = {entry_tag[issue_idx], entry_set[issue_idx]};

	assign response_match = cpi_valid_i && cpi_unit_i == UNIT_ID && entry_valid[cpi_strand_i];
	assign load_complete_strands_o = response_match ? entry_waiting[cpi_strand_i] : '0;
	assign load_complete_set_o = entry_set[cpi_strand_i];
	assign load_complete_tag_o = entry_tag[cpi_strand_i];
	assign load_complete_way_o = entry_way[cpi_strand_i];

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			entry_valid <= '0;
			entry_issued <= '0;
			rr_ptr <= '0;
			held <= 1'b0;
			held_idx <= '0;
			for (int e = 0; e < NUM_ENTRIES; e++)
				entry_waiting[e] <= '0;
		end
		else
		begin
			if (pci_valid_o && pci_ack_i)
			begin
				entry_issued[issue_idx] <= 1'b1;
				rr_ptr <= issue_idx + 1'b1;
				held <= 1'b0;
			end
			else if (pci_valid_o)
			begin
				held <= 1'b1;
				held_idx <= issue_idx;
			end

			if (response_match)
			begin
				entry_valid[cpi_strand_i] <= 1'b0;
				entry_waiting[cpi_strand_i] <= '0;
			end

			if (request_i)
			begin
				if (|merge_hit)
					entry_waiting[merge_idx] <= entry_waiting[merge_idx] | strand_bit;
				else
				begin
					entry_valid[strand_i] <= 1'b1;
					entry_issued[strand_i] <= 1'b0;
					entry_waiting[strand_i] <= strand_bit;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (request_i && !(|merge_hit))
		begin
			entry_tag[strand_i] <= tag_i;
			entry_set[strand_i] <= set_i;
			entry_way[strand_i] <= victim_way_i;
		end
	end

	// The core must hold a strand back while its load is outstanding
	assert property (@(posedge clk) disable iff (!rst_n_i)
		request_i |-> (waiting_all & strand_bit) == '0)
		else $error("access from a strand with a pending miss");

endmodule

`default_nettype wire

/* rtl/l1_cache.sv */
// L1 cache with parallel tag and way lookup, pseudo-LRU and a non-blocking miss queue
`default_nettype none

`include "l1_cache_macros.svh"

module l1_cache
	#(parameter l1_cache_pkg::unit_t UNIT_ID = 2'd0)
	(
	input wire clk,
	input wire rst_n_i,
	input wire [31:0] address_i,
	input wire l1_cache_pkg::strand_t strand_i,
	input wire access_i,
	output l1_cache_pkg::cache_line_t data_o,
	output logic cache_hit_o,
	output l1_cache_pkg::strand_mask_t load_complete_strands_o,
	output logic load_collision_o,
	output logic pci_valid_o,
	input wire pci_ack_i,
	output l1_cache_pkg::strand_t pci_strand_o,
	output l1_cache_pkg::line_addr_t pci_address_o,
	input wire cpi_valid_i,
	input wire l1_cache_pkg::unit_t cpi_unit_i,
	input wire l1_cache_pkg::strand_t cpi_strand_i,
	input wire l1_cache_pkg::cache_line_t cpi_data_i
	);

	import l1_cache_pkg::*;

	l1_set_t requested_set;
	l1_tag_t requested_tag;
	logic access_q;
	l1_set_t set_q;
	l1_tag_t tag_q;
	strand_t strand_q;
	l1_way_t hit_way;
	l1_way_t lru_way;
	l1_way_t used_way;
	l1_set_t load_complete_set;
	l1_tag_t load_complete_tag;
	l1_way_t load_complete_way;
	logic collision1_q;
	logic collision2;
	logic queue_miss;
	cache_line_t way_data [`L1_NUM_WAYS][`L1_NUM_SETS];
	cache_line_t way_read [`L1_NUM_WAYS];

	assign requested_set = address_i[`L1_OFFSET_WIDTH +: `L1_SET_INDEX_WIDTH];
	assign requested_tag = address_i[`L1_OFFSET_WIDTH + `L1_SET_INDEX_WIDTH +: `L1_TAG_WIDTH];

	l1_cache_tag tag_mem (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.lookup_set_i(requested_set),
		.lookup_tag_i(requested_tag),
		.access_i(access_i),
		.hit_way_o(hit_way),
		.cache_hit_o(cache_hit_o),
		.update_i(|load_complete_strands_o),
		.update_set_i(load_complete_set),
		.update_tag_i(load_complete_tag),
		.update_way_i(load_complete_way));

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			access_q <= 1'b0;
			collision1_q <= 1'b0;
		end
		else
		begin
			access_q <= access_i;
			// The fill lands after this lookup has read the old tags
			collision1_q <= access_i && |load_complete_strands_o
				&& load_complete_tag == requested_tag
				&& load_complete_set == requested_set;
		end
	end

	// All four ways are read alongside the tags, the fill writes one of them
	always_ff @(posedge clk)
	begin
		set_q <= requested_set;
		tag_q <= requested_tag;
		strand_q <= strand_i;
		for (int w = 0; w < `L1_NUM_WAYS; w++)
			way_read[w] <= way_data[w][requested_set];
		if (|load_complete_strands_o)
			way_data[load_complete_way][load_complete_set] <= cpi_data_i;
	end

	assign data_o = way_read[hit_way];

	// A fill for the line we missed on is retiring this cycle, so a new miss would be lost
	assign collision2 = access_q && |load_complete_strands_o
		&& load_complete_tag == tag_q
		&& load_complete_set == set_q;

	assign load_collision_o = collision1_q || collision2;
	assign queue_miss = access_q && !cache_hit_o && !load_collision_o;

	// The victim is marked used so the next miss picks another way
	assign used_way = cache_hit_o ? hit_way : lru_way;

	l1_cache_lru lru (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.set_i(requested_set),
		.update_i(access_q),
		.used_way_i(used_way),
		.lru_way_o(lru_way));

	l1_miss_queue #(.UNIT_ID(UNIT_ID)) miss_queue (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.request_i(queue_miss),
		.tag_i(tag_q),
		.set_i(set_q),
		.victim_way_i(lru_way),
		.strand_i(strand_q),
		.pci_valid_o(pci_valid_o),
		.pci_ack_i(pci_ack_i),
		.pci_strand_o(pci_strand_o),
		.pci_address_o(pci_address_o),
		.cpi_valid_i(cpi_valid_i),
		.cpi_unit_i(cpi_unit_i),
		.cpi_strand_i(cpi_strand_i),
		.load_complete_strands_o(load_complete_strands_o),
		.load_complete_set_o(load_complete_set),
		.load_complete_tag_o(load_complete_tag),
		.load_complete_way_o(load_complete_way));

endmodule

`default_nettype wire

/* rtl/l2_request_arbiter.sv */
// Round-robin arbiter for the shared L2 request bus, holding each grant until ack
`default_nettype none

module l2_request_arbiter
	(
	input wire clk,
	input wire rst_n_i,
	input wire req0_valid_i,
	input wire l1_cache_pkg::strand_t req0_strand_i,
	input wire l1_cache_pkg::line_addr_t req0_address_i,
	output logic req0_ack_o,
	input wire req1_valid_i,
	input wire l1_cache_pkg::strand_t req1_strand_i,
	input wire l1_cache_pkg::line_addr_t req1_address_i,
	output logic req1_ack_o,
	output logic pci_valid_o,
	output l1_cache_pkg::unit_t pci_unit_o,
	output l1_cache_pkg::strand_t pci_strand_o,
	output l1_cache_pkg::line_addr_t pci_address_o,
	input wire pci_ack_i
	);

	import l1_cache_pkg::*;

	logic grant_held;
	logic grant_idx;
	logic last_served;
	logic sel;

	always_comb
	begin
		if (grant_held)
			sel = grant_idx;
		else if (req0_valid_i && req1_valid_i)
			sel = ~last_served;
		else
			sel = req1_valid_i;
	end

	assign pci_valid_o = sel ? req1_valid_i : req0_valid_i;
	assign pci_strand_o = sel ? req1_strand_i : req0_strand_i;
	assign pci_address_o = sel ? req1_address_i : req0_address_i;
	// Cache unit numbers equal their input index here
	assign pci_unit_o = unit_t'(sel);
	assign req0_ack_o = pci_ack_i && pci_valid_o && !sel;
	assign req1_ack_o = pci_ack_i && pci_valid_o && sel;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			grant_held <= 1'b0;
			grant_idx <= 1'b0;
			// Unit 0 wins the first tie
			last_served <= 1'b1;
		end
		else if (pci_valid_o && pci_ack_i)
		begin
			grant_held <= 1'b0;
			last_served <= sel;
		end
		else if (pci_valid_o)
		begin
			grant_held <= 1'b1;
			grant_idx <= sel;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		pci_valid_o && !pci_ack_i |=> pci_valid_o && $stable(pci_unit_o)
			&& $stable(pci_strand_o) && $stable(pci_address_o))
		else $error("L2 request changed before ack");

endmodule

`default_nettype wire

/* rtl/l1_cache_pair.sv */
// Instruction and data L1 caches sharing one L2 request bus through an arbiter
`default_nettype none

module l1_cache_pair
	(
	input wire clk,
	input wire rst_n_i,
	input wire [31:0] i_address_i,
	input wire l1_cache_pkg::strand_t i_strand_i,
	input wire i_access_i,
	output l1_cache_pkg::cache_line_t i_data_o,
	output logic i_cache_hit_o,
	output l1_cache_pkg::strand_mask_t i_load_complete_strands_o,
	output logic i_load_collision_o,
	input wire [31:0] d_address_i,
	input wire l1_cache_pkg::strand_t d_strand_i,
	input wire d_access_i,
	output l1_cache_pkg::cache_line_t d_data_o,
	output logic d_cache_hit_o,
	output l1_cache_pkg::strand_mask_t d_load_complete_strands_o,
	output logic d_load_collision_o,
	output logic pci_valid_o,
	input wire pci_ack_i,
	output l1_cache_pkg::unit_t pci_unit_o,
	output l1_cache_pkg::strand_t pci_strand_o,
	output l1_cache_pkg::line_addr_t pci_address_o,
	input wire cpi_valid_i,
	input wire l1_cache_pkg::unit_t cpi_unit_i,
	input wire l1_cache_pkg::strand_t cpi_strand_i,
	input wire l1_cache_pkg::cache_line_t cpi_data_i
	);

	import l1_cache_pkg::*;

	logic i_pci_valid;
	logic i_pci_ack;
	strand_t i_pci_strand;
	line_addr_t i_pci_address;
	logic d_pci_valid;
	logic d_pci_ack;
	strand_t d_pci_strand;
	line_addr_t d_pci_address;

	l1_cache #(.UNIT_ID(2'd0)) icache (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.address_i(i_address_i),
		.strand_i(i_strand_i),
		.access_i(i_access_i),
		.data_o(i_data_o),
		.cache_hit_o(i_cache_hit_o),
		.load_complete_strands_o(i_load_complete_strands_o),
		.load_collision_o(i_load_collision_o),
		.pci_valid_o(i_pci_valid),
		.pci_ack_i(i_pci_ack),
		.pci_strand_o(i_pci_strand),
		.pci_address_o(i_pci_address),
		.cpi_valid_i(cpi_valid_i),
		.cpi_unit_i(cpi_unit_i),
		.cpi_strand_i(cpi_strand_i),
		.cpi_data_i(cpi_data_i));

	l1_cache #(.UNIT_ID(2'd1)) dcache (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.address_i(d_address_i),
		.strand_i(d_strand_i),
		.access_i(d_access_i),
		.data_o(d_data_o),
		.cache_hit_o(d_cache_hit_o),
		.load_complete_strands_o(d_load_complete_strands_o),
		.load_collision_o(d_load_collision_o),
		.pci_valid_o(d_pci_valid),
		.pci_ack_i(d_pci_ack),
		.pci_strand_o(d_pci_strand),
		.pci_address_o(d_pci_address),
		.cpi_valid_i(cpi_valid_i),
		.cpi_unit_i(cpi_unit_i),
		.cpi_strand_i(cpi_strand_i),
		.cpi_data_i(cpi_data_i));

	// Input index must match each cache's unit number
	l2_request_arbiter arbiter (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.req0_valid_i(i_pci_valid),
		.req0_strand_i(i_pci_strand),
		.req0_address_i(i_pci_address),
		.req0_ack_o(i_pci_ack),
		.req1_valid_i(d_pci_valid),
		.req1_strand_i(d_pci_strand),
		.req1_address_i(d_pci_address),
		.req1_ack_o(d_pci_ack),
		.pci_valid_o(pci_valid_o),
		.pci_unit_o(pci_unit_o),
		.pci_strand_o(pci_strand_o),
		.pci_address_o(pci_address_o),
		.pci_ack_i(pci_ack_i));

endmodule

`default_nettype wire

/* verif/l1_cache_pair_tb.sv */
// Testbench for the L1 cache pair with an L2 model, a stimulus table and a reference model
`default_nettype none

`include "l1_cache_macros.svh"

module l1_cache_pair_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import l1_cache_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam logic [1:0] K_HIT = 2'd0;
	localparam logic [1:0] K_MISS = 2'd1;
	localparam logic [1:0] K_COLL = 2'd2;
	localparam logic [1:0] C_I = 2'd0;
	localparam logic [1:0] C_D = 2'd1;
	localparam logic [1:0] C_BOTH = 2'd2;
	localparam logic [2:0] L2_IDLE = 3'd0;
	localparam logic [2:0] L2_ACK_WAIT = 3'd1;
	localparam logic [2:0] L2_ACKED = 3'd2;
	localparam logic [2:0] L2_RESP_WAIT = 3'd3;
	localparam logic [2:0] L2_RESP = 3'd4;

	// One access per row, settle waits for every queued miss to be filled
	typedef struct packed
	{
		logic [1:0] cache;
		strand_t strand;
		logic [31:0] addr;
		logic [1:0] kind;
		logic settle;
	} row_t;

	logic clk = 1'b0;
	logic rst_n_i;
	logic [31:0] i_address_i;
	strand_t i_strand_i;
	logic i_access_i;
	cache_line_t i_data_o;
	logic i_cache_hit_o;
	strand_mask_t i_load_complete_strands_o;
	logic i_load_collision_o;
	logic [31:0] d_address_i;
	strand_t d_strand_i;
	logic d_access_i;
	cache_line_t d_data_o;
	logic d_cache_hit_o;
	strand_mask_t d_load_complete_strands_o;
	logic d_load_collision_o;
	logic pci_valid_o;
	logic pci_ack_i;
	unit_t pci_unit_o;
	strand_t pci_strand_o;
	line_addr_t pci_address_o;
	logic cpi_valid_i;
	unit_t cpi_unit_i;
	strand_t cpi_strand_i;
	cache_line_t cpi_data_i;

	logic [2:0] l2_state = L2_IDLE;
	logic [1:0] l2_count = '0;
	unit_t l2_unit = '0;
	strand_t l2_strand = '0;
	line_addr_t l2_addr = '0;
	logic [7:0] lfsr_state = 8'd6;
	logic resp_next;

	unit_t req_unit_q [$];
	line_addr_t req_addr_q [$];
	strand_t req_strand_q [$];
	strand_mask_t i_comp_q [$];
	strand_mask_t d_comp_q [$];

	// Reference model of tags, tree bits and the one outstanding line per cache
	l1_tag_t m_tag [2][`L1_NUM_SETS][`L1_NUM_WAYS];
	logic m_valid [2][`L1_NUM_SETS][`L1_NUM_WAYS];
	logic [2:0] m_tree [2][`L1_NUM_SETS];
	logic pend_valid [2];
	line_addr_t pend_line [2];
	strand_mask_t pend_mask [2];
	l1_way_t pend_way [2];
	strand_t pend_strand [2];
	logic last_unit;
	int error_count;
	row_t rows [26];

	l1_cache_pair DUT (.*);

	always #2 clk = ~clk;

	// Fibonacci LFSR with taps 8, 6, 5 and 4, one step per bit taken
	function automatic logic [1:0] take_bits(input int n);
		logic [1:0] v;
		logic fb;
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
			lfsr_state = {lfsr_state[6:0], fb};
			v = {v[0], fb};
		end
		return v;
	endfunction

	// Word w of a line holds the line address times 16 plus w
	function automatic cache_line_t line_data(input line_addr_t la);
		cache_line_t line;
		for (int w = 0; w < 16; w++)
			line[32*w +: 32] = {6'b0, la} * 32'd16 + 32'(w);
		return line;
	endfunction

	assign resp_next = l2_state == L2_RESP_WAIT && l2_count == 2'd0;

	// L2 model serves one request at a time
	always @(posedge clk)
	begin
		case (l2_state)
			L2_IDLE:
				if (rst_n_i && pci_valid_o)
				begin
					l2_count <= take_bits(2);
					l2_state <= L2_ACK_WAIT;
				end
			L2_ACK_WAIT:
				if (l2_count == 2'd0)
				begin
					pci_ack_i <= 1'b1;
					l2_state <= L2_ACKED;
				end
				else
					l2_count <= l2_count - 2'd1;
			L2_ACKED:
			begin
				pci_ack_i <= 1'b0;
				l2_unit <= pci_unit_o;
				l2_strand <= pci_strand_o;
				l2_addr <= pci_address_o;
				l2_count <= take_bits(2);
				l2_state <= L2_RESP_WAIT;
			end
			L2_RESP_WAIT:
				if (l2_count == 2'd0)
				begin
					cpi_valid_i <= 1'b1;
					cpi_unit_i <= l2_unit;
					cpi_strand_i <= l2_strand;
					cpi_data_i <= line_data(l2_addr);
					l2_state <= L2_RESP;
				end
				else
					l2_count <= l2_count - 2'd1;
			default:
			begin
				cpi_valid_i <= 1'b0;
				l2_state <= L2_IDLE;
			end
		endcase
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		error_count++;
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_line(input cache_line_t act, input cache_line_t exp, input string what);
		if (act !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, what, act, exp));
	endtask

	task automatic check_mask(input strand_mask_t act, input strand_mask_t exp, input string what);
		if (act !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b", $time, what, act, exp));
	endtask

	task automatic check_addr(input line_addr_t act, input line_addr_t exp, input string what);
		if (act !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, what, act, exp));
	endtask

	task automatic check_unit(input unit_t act, input unit_t exp, input string what);
		if (act !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, act, exp));
	endtask

	task automatic check_strand(input strand_t act, input strand_t exp, input string what);
		if (act !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, act, exp));
	endtask

	task automatic check_flag(input logic act, input logic exp, input string what);
		if (act !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b", $time, what, act, exp));
	endtask

	// Requests and completion pulses are logged mid-cycle
	always @(negedge clk)
	begin
		if (rst_n_i)
		begin
			if (pci_valid_o && pci_ack_i)
			begin
				req_unit_q.push_back(pci_unit_o);
				req_addr_q.push_back(pci_address_o);
				req_strand_q.push_back(pci_strand_o);
			end
			if (|i_load_complete_strands_o)
			begin
				if (!(cpi_valid_i && cpi_unit_i == 2'd0))
					fail_run("Instruction cache completed a load without a response of its own");
				i_comp_q.push_back(i_load_complete_strands_o);
			end
			if (|d_load_complete_strands_o)
			begin
				if (!(cpi_valid_i && cpi_unit_i == 2'd1))
					fail_run("Data cache completed a load without a response of its own");
				d_comp_q.push_back(d_load_complete_strands_o);
			end
		end
	end

	function automatic l1_way_t model_victim(input int c, input l1_set_t s);
		return m_tree[c][s][0] ? {1'b1, m_tree[c][s][2]} : {1'b0, m_tree[c][s][1]};
	endfunction

	// Each bit on the used path turns to the other half
	task automatic model_use(input int c, input l1_set_t s, input l1_way_t w);
		m_tree[c][s][0] = ~w[1];
		if (w[1])
			m_tree[c][s][2] = ~w[0];
		else
			m_tree[c][s][1] = ~w[0];
	endtask

	task automatic evaluate_result(input int c, input row_t row);
		l1_set_t s;
		l1_tag_t t;
		logic hit;
		l1_way_t way;
		l1_way_t victim;
		s = row.addr[10:6];
		t = row.addr[31:11];
		hit = 1'b0;
		way = '0;
		for (int w = 0; w < `L1_NUM_WAYS; w++)
		begin
			if (m_valid[c][s][w] && m_tag[c][s][w] == t)
			begin
				hit = 1'b1;
				way = l1_way_t'(w);
			end
		end
		if (hit != (row.kind == K_HIT))
			fail_run($sformatf("Table row for address %h disagrees with the reference model", row.addr));
		check_flag(c ? d_cache_hit_o : i_cache_hit_o, hit, $sformatf("hit for cache %0d", c));
		check_flag(c ? d_load_collision_o : i_load_collision_o, row.kind == K_COLL,
			$sformatf("collision for cache %0d", c));
		if (hit)
		begin
			check_line(c ? d_data_o : i_data_o, line_data({t, s}), $sformatf("line of cache %0d", c));
			model_use(c, s, way);
		end
		else
		begin
			victim = model_victim(c, s);
			if (row.kind == K_MISS)
			begin
				if (pend_valid[c] && pend_line[c] == {t, s})
					pend_mask[c] = pend_mask[c] | strand_mask_t'(1 << row.strand);
				else
				begin
					pend_valid[c] = 1'b1;
					pend_line[c] = {t, s};
					pend_mask[c] = strand_mask_t'(1 << row.strand);
					pend_way[c] = victim;
					pend_strand[c] = row.strand;
				end
			end
			model_use(c, s, victim);
		end
	endtask

	task automatic wait_for_fill();
		int t;
		t = 0;
		@(posedge clk);
		while (!resp_next)
		begin
			if (t >= WAIT_LIMIT)
				fail_run("Timed out waiting for an L2 response to arrive");
			t++;
			@(posedge clk);
		end
	endtask

	task automatic settle_misses();
		int np;
		int t;
		int order [2];
		int u;
		np = int'(pend_valid[0]) + int'(pend_valid[1]);
		t = 0;
		while (i_comp_q.size() + d_comp_q.size() < np)
		begin
			if (t >= WAIT_LIMIT)
				fail_run("Timed out waiting for a load to complete");
			t++;
			@(negedge clk);
		end
		// Quiet time so that an extra request or completion shows up
		repeat (12) @(negedge clk);
		if (req_unit_q.size() != np)
			fail_run($sformatf("Saw %0d L2 requests where %0d were due", req_unit_q.size(), np));
		if (i_comp_q.size() != int'(pend_valid[0]) || d_comp_q.size() != int'(pend_valid[1]))
			fail_run("Number of completion pulses is wrong");
		// With both caches waiting, the unit not served last goes first
		order[0] = pend_valid[0] && pend_valid[1] ? int'(!last_unit) : int'(pend_valid[1]);
		order[1] = 1 - order[0];
		for (int k = 0; k < np; k++)
		begin
			u = order[k];
			check_unit(req_unit_q.pop_front(), unit_t'(u), "request unit");
			check_addr(req_addr_q.pop_front(), pend_line[u], "request address");
			check_strand(req_strand_q.pop_front(), pend_strand[u], "request strand");
			check_mask(u ? d_comp_q.pop_front() : i_comp_q.pop_front(), pend_mask[u],
				"completion strands");
			last_unit = u[0];
			m_tag[u][pend_line[u][4:0]][pend_way[u]] = pend_line[u][25:5];
			m_valid[u][pend_line[u][4:0]][pend_way[u]] = 1'b1;
			pend_valid[u] = 1'b0;
		end
	endtask

	initial
	begin
		rst_n_i <= 1'b0;
		i_address_i <= '0;
		i_strand_i <= '0;
		i_access_i <= 1'b0;
		d_address_i <= '0;
		d_strand_i <= '0;
		d_access_i <= 1'b0;
		pci_ack_i <= 1'b0;
		cpi_valid_i <= 1'b0;
		cpi_unit_i <= '0;
		cpi_strand_i <= '0;
		cpi_data_i <= '0;
		error_count = 0;
		last_unit = 1'b1;
		for (int c = 0; c < 2; c++)
		begin
			pend_valid[c] = 1'b0;
			for (int s = 0; s < `L1_NUM_SETS; s++)
			begin
				m_tree[c][s] = 3'b000;
				for (int w = 0; w < `L1_NUM_WAYS; w++)
					m_valid[c][s][w] = 1'b0;
			end
		end
		rows = '{
			'{C_I, 2'd0, 32'h0001_2344, K_MISS, 1'b1},
			'{C_I, 2'd1, 32'h0001_2344, K_HIT, 1'b0},
			'{C_D, 2'd0, 32'h0003_4500, K_MISS, 1'b1},
			'{C_D, 2'd2, 32'h0003_4508, K_HIT, 1'b0},
			'{C_D, 2'd1, 32'h0004_5680, K_MISS, 1'b0},
			'{C_D, 2'd2, 32'h0004_5690, K_MISS, 1'b1},
			'{C_D, 2'd3, 32'h0004_56A0, K_HIT, 1'b0},
			'{C_I, 2'd0, 32'h0000_08C0, K_MISS, 1'b1},
			'{C_I, 2'd0, 32'h0000_10C0, K_MISS, 1'b1},
			'{C_I, 2'd0, 32'h0000_18C0, K_MISS, 1'b1},
			'{C_I, 2'd0, 32'h0000_20C0, K_MISS, 1'b1},
			'{C_I, 2'd1, 32'h0000_08C0, K_HIT, 1'b0},
			'{C_I, 2'd0, 32'h0000_28C0, K_MISS, 1'b1},
			'{C_I, 2'd1, 32'h0000_08C0, K_HIT, 1'b0},
			'{C_I, 2'd1, 32'h0000_18C0, K_HIT, 1'b0},
			'{C_I, 2'd1, 32'h0000_20C0, K_HIT, 1'b0},
			'{C_I, 2'd1, 32'h0000_28C0, K_HIT, 1'b0},
			'{C_I, 2'd0, 32'h0000_10C0, K_MISS, 1'b1},
			'{C_BOTH, 2'd2, 32'h0009_A000, K_MISS, 1'b1},
			'{C_D, 2'd3, 32'h000A_B000, K_MISS, 1'b1},
			'{C_BOTH, 2'd1, 32'h000B_C040, K_MISS, 1'b1},
			'{C_BOTH, 2'd0, 32'h0009_A000, K_HIT, 1'b0},
			'{C_BOTH, 2'd0, 32'h000B_C040, K_HIT, 1'b0},
			'{C_D, 2'd0, 32'h0007_8000, K_MISS, 1'b0},
			'{C_D, 2'd3, 32'h0007_8010, K_COLL, 1'b1},
			'{C_D, 2'd1, 32'h0007_8020, K_HIT, 1'b0}
		};
		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int r = 0; r < 26; r++)
		begin
			// A collision row lands in the cycle the fill is written
			if (rows[r].kind == K_COLL)
				wait_for_fill();
			else
				@(posedge clk);
			if (rows[r].cache != C_D)
			begin
				i_address_i <= rows[r].addr;
				i_strand_i <= rows[r].strand;
				i_access_i <= 1'b1;
			end
			if (rows[r].cache != C_I)
			begin
				d_address_i <= rows[r].addr;
				d_strand_i <= rows[r].strand;
				d_access_i <= 1'b1;
			end
			@(posedge clk);
			i_access_i <= 1'b0;
			d_access_i <= 1'b0;
			@(negedge clk);
			if (rows[r].cache != C_D)
				evaluate_result(0, rows[r]);
			if (rows[r].cache != C_I)
				evaluate_result(1, rows[r]);
			if (rows[r].settle)
				settle_misses();
		end
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+rtl
rtl/l1_cache_pkg.sv
rtl/l1_cache_tag.sv
rtl/l1_cache_lru.sv
rtl/l1_miss_queue.sv
rtl/l1_cache.sv
rtl/l2_request_arbiter.sv
rtl/l1_cache_pair.sv
verif/l1_cache_pair_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the L1 cache pair testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f \
	--top-module l1_cache_pair_tb -o l1_cache_pair_sim
if [ $? -ne 0 ]; then
	echo "Compilation failed"
	exit 1
fi

./obj_dir/l1_cache_pair_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0
